// ==== logic/ladc_config.svh ====
`ifndef LADC_CONFIG_SVH
`define LADC_CONFIG_SVH

// SPI word width in bits
`define LADC_DATA_W 16

// One ADC plus seven DACs
`define LADC_NUM_DEV 8

// Command queue entries
// The host starts with this many command credits
`define LADC_QUEUE_DEPTH 4

// Response credits held by the engine after reset
`define LADC_RSP_CREDITS 2

// System clock cycles per SCK half period
`define LADC_SCK_HALF 2

`endif

// ==== logic/ladc_pkg.sv ====
`include "ladc_config.svh"

package ladc_pkg;

    // One SPI word
    typedef logic [`LADC_DATA_W-1:0] ladc_data_t;

    // Device index, 0 is the ADC and 1 to 7 are the DACs
    typedef logic [$clog2(`LADC_NUM_DEV)-1:0] ladc_dev_t;

    // One-hot device select
    typedef logic [`LADC_NUM_DEV-1:0] ladc_sel_t;

    // Shift engine states
    typedef enum logic [2:0] {
        IDLE,
        SELECT,
        SHIFT,
        DESELECT,
        DONE
    } spi_state_t;

endpackage

// ==== logic/spi_cmd_queue.sv ====
`timescale 1ns/1ps
`include "ladc_config.svh"

module spi_cmd_queue import ladc_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       cmd_valid_i,
    input  ladc_dev_t  cmd_dev_i,
    input  ladc_data_t cmd_data_i,
    output logic       cmd_credit_o,
    input  logic       pop_i,
    output logic       valid_o,
    output ladc_dev_t  dev_o,
    output ladc_data_t data_o
);

    localparam int PTR_W = $clog2(`LADC_QUEUE_DEPTH);
    localparam int CNT_W = $clog2(`LADC_QUEUE_DEPTH + 1);

    ladc_dev_t  dev_mem  [`LADC_QUEUE_DEPTH];
    ladc_data_t data_mem [`LADC_QUEUE_DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             full;
    logic             wr_en;
    logic             rd_en;

    assign full    = (count == CNT_W'(`LADC_QUEUE_DEPTH));
    assign valid_o = (count != '0);
    assign wr_en   = cmd_valid_i && !full;
    assign rd_en   = pop_i && valid_o;

    assign dev_o  = dev_mem[rd_ptr];
    assign data_o = data_mem[rd_ptr];

    always_ff @(posedge clk_i) begin
        if (wr_en) begin
            dev_mem[wr_ptr]  <= cmd_dev_i;
            data_mem[wr_ptr] <= cmd_data_i;
        end
    end

    // Pointers wrap naturally, depth is a power of two
    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            wr_ptr       <= '0;
            rd_ptr       <= '0;
            count        <= '0;
            cmd_credit_o <= 1'b0;
        end else begin
            if (wr_en) begin
                wr_ptr <= wr_ptr + 1'b1;
            end
            if (rd_en) begin
                rd_ptr <= rd_ptr + 1'b1;
            end
            count        <= count + CNT_W'(wr_en) - CNT_W'(rd_en);
            // One credit back per entry that leaves
            cmd_credit_o <= rd_en;
        end
    end

    // Host wrote without holding a credit
    a_no_write_full: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) !(cmd_valid_i && full)
    );

    a_no_pop_empty: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) !(pop_i && !valid_o)
    );

endmodule

// ==== logic/spi_shift_engine.sv ====
`timescale 1ns/1ps
`include "ladc_config.svh"

module spi_shift_engine import ladc_pkg::*; (
    input  logic       clk_i,
    input  logic       arst_n_i,
    input  logic       q_valid_i,
    input  ladc_dev_t  q_dev_i,
    input  ladc_data_t q_data_i,
    output logic       q_pop_o,
    input  logic       rsp_credit_i,
    output ladc_dev_t  xfer_dev_o,
    output logic       cs_active_o,
    output logic       sck_o,
    output logic       mosi_o,
    input  logic       miso_i,
    output logic       rsp_valid_o,
    output ladc_dev_t  rsp_dev_o,
    output ladc_data_t rsp_data_o
);

    localparam int DIV_W = $clog2(2 * `LADC_SCK_HALF);
    localparam int BIT_W = $clog2(`LADC_DATA_W);
    localparam int CRD_W = $clog2(`LADC_RSP_CREDITS + 1);

    localparam logic [DIV_W-1:0] DIV_RISE = DIV_W'(`LADC_SCK_HALF - 1);
    localparam logic [DIV_W-1:0] DIV_FALL = DIV_W'(2 * `LADC_SCK_HALF - 1);
    localparam logic [BIT_W-1:0] BIT_LAST = BIT_W'(`LADC_DATA_W - 1);

    spi_state_t       state;
    logic [DIV_W-1:0] div_cnt;
    logic [BIT_W-1:0] bit_cnt;
    logic [CRD_W-1:0] rsp_cred;
    ladc_data_t       tx_sr;
    ladc_data_t       rx_sr;
    ladc_dev_t        dev_r;
    logic             start;
    logic             sck_rise;
    logic             sck_fall;

    // Needs a queued command and a response credit
    assign start    = (state == IDLE) && q_valid_i && (rsp_cred != '0);
    assign sck_rise = (state == SHIFT) && (div_cnt == DIV_RISE);
    assign sck_fall = (state == SHIFT) && (div_cnt == DIV_FALL);

    assign q_pop_o     = start;
    assign cs_active_o = (state == SELECT) || (state == SHIFT);
    // Mode 0, SCK idles low and is high in the second half of each period
    assign sck_o       = (state == SHIFT) && (div_cnt > DIV_RISE);
    assign mosi_o      = cs_active_o && tx_sr[`LADC_DATA_W-1];
    assign xfer_dev_o  = dev_r;
    assign rsp_valid_o = (state == DONE);
    assign rsp_dev_o   = dev_r;
    assign rsp_data_o  = rx_sr;

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            state   <= IDLE;
            div_cnt <= '0;
            bit_cnt <= '0;
        end else begin
            unique case (state)
                IDLE: begin
                    if (start) begin
                        state <= SELECT;
                    end
                end
                SELECT: begin
                    state   <= SHIFT;
                    div_cnt <= '0;
                    bit_cnt <= '0;
                end
                SHIFT: begin
                    if (sck_fall) begin
                        div_cnt <= '0;
                        bit_cnt <= bit_cnt + 1'b1;
                        if (bit_cnt == BIT_LAST) begin
                            state <= DESELECT;
                        end
                    end else begin
                        div_cnt <= div_cnt + 1'b1;
                    end
                end
                DESELECT: state <= DONE;
                DONE:     state <= IDLE;
                default:  state <= IDLE;
            endcase
        end
    end

    // Shift registers, MSB first in both directions
    always_ff @(posedge clk_i) begin
        if (start) begin
            tx_sr <= q_data_i;
            dev_r <= q_dev_i;
        end else if (sck_fall) begin
            tx_sr <= {tx_sr[`LADC_DATA_W-2:0], 1'b0};
        end
        if (sck_rise) begin
            rx_sr <= {rx_sr[`LADC_DATA_W-2:0], miso_i};
        end
    end

    always_ff @(posedge clk_i or negedge arst_n_i) begin
        if (!arst_n_i) begin
            rsp_cred <= CRD_W'(`LADC_RSP_CREDITS);
        end else begin
            rsp_cred <= rsp_cred - CRD_W'(start) + CRD_W'(rsp_credit_i);
        end
    end

    // Host returned more response credits than it was given
    a_rsp_cred_max: assert property (
        @(posedge clk_i) disable iff (!arst_n_i) rsp_cred <= CRD_W'(`LADC_RSP_CREDITS)
    );

endmodule

// ==== logic/spi_dev_router.sv ====
`timescale 1ns/1ps
`include "ladc_config.svh"

module spi_dev_router import ladc_pkg::*; (
    input  ladc_dev_t                xfer_dev_i,
    input  logic                     cs_active_i,
    output logic                     miso_o,
    output logic                     adc_cs_n_o,
    output logic [`LADC_NUM_DEV-2:0] dac_cs_n_o,
    input  logic                     adc_miso_i,
    input  logic [`LADC_NUM_DEV-2:0] dac_sdo_i
);

    ladc_sel_t sel;
    ladc_sel_t cs_vec;
    ladc_sel_t miso_vec;

    // Bit 0 is the ADC, bits 1 up are the DACs
    assign sel      = ladc_sel_t'(1) << xfer_dev_i;
    assign cs_vec   = sel & {`LADC_NUM_DEV{cs_active_i}};
    assign miso_vec = {dac_sdo_i, adc_miso_i};

    assign adc_cs_n_o = ~cs_vec[0];
    assign dac_cs_n_o = ~cs_vec[`LADC_NUM_DEV-1:1];

    // One-hot mux of the returned data lines
    assign miso_o = |(miso_vec & sel);

endmodule

// ==== logic/ladc_spi_top.sv ====
`timescale 1ns/1ps
`include "ladc_config.svh"

module ladc_spi_top import ladc_pkg::*; (
    input  logic                     clk_i,
    input  logic                     arst_n_i,
    input  logic                     cmd_valid_i,
    input  ladc_dev_t                cmd_dev_i,
    input  ladc_data_t               cmd_data_i,
    output logic                     cmd_credit_o,
    input  logic                     rsp_credit_i,
    output logic                     rsp_valid_o,
    output ladc_dev_t                rsp_dev_o,
    output ladc_data_t               rsp_data_o,
    output logic                     spi_sck_o,
    output logic                     spi_mosi_o,
    output logic                     adc_cs_n_o,
    output logic [`LADC_NUM_DEV-2:0] dac_cs_n_o,
    input  logic                     adc_miso_i,
    input  logic [`LADC_NUM_DEV-2:0] dac_sdo_i
);

    logic       q_valid;
    ladc_dev_t  q_dev;
    ladc_data_t q_data;
    logic       q_pop;
    ladc_dev_t  xfer_dev;
    logic       cs_active;
    logic       miso_sel;

    spi_cmd_queue u_queue (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .cmd_valid_i  (cmd_valid_i),
        .cmd_dev_i    (cmd_dev_i),
        .cmd_data_i   (cmd_data_i),
        .cmd_credit_o (cmd_credit_o),
        .pop_i        (q_pop),
        .valid_o      (q_valid),
        .dev_o        (q_dev),
        .data_o       (q_data)
    );

    spi_shift_engine u_engine (
        .clk_i        (clk_i),
        .arst_n_i     (arst_n_i),
        .q_valid_i    (q_valid),
        .q_dev_i      (q_dev),
        .q_data_i     (q_data),
        .q_pop_o      (q_pop),
        .rsp_credit_i (rsp_credit_i),
        .xfer_dev_o   (xfer_dev),
        .cs_active_o  (cs_active),
        .sck_o        (spi_sck_o),
        .mosi_o       (spi_mosi_o),
        .miso_i       (miso_sel),
        .rsp_valid_o  (rsp_valid_o),
        .rsp_dev_o    (rsp_dev_o),
        .rsp_data_o   (rsp_data_o)
    );

    // SCK and MOSI go straight to every device
    spi_dev_router u_router (
        .xfer_dev_i  (xfer_dev),
        .cs_active_i (cs_active),
        .miso_o      (miso_sel),
        .adc_cs_n_o  (adc_cs_n_o),
        .dac_cs_n_o  (dac_cs_n_o),
        .adc_miso_i  (adc_miso_i),
        .dac_sdo_i   (dac_sdo_i)
    );

endmodule

// ==== verif/ladc_spi_tb.sv ====
`timescale 1ns/1ps
`include "ladc_config.svh"

module ladc_spi_tb import ladc_pkg::*; ();

    localparam int NUM_CMDS    = 200;
    localparam int TIMEOUT     = NUM_CMDS * 150;
    // SELECT, 16 SCK periods, DESELECT, then DONE
    localparam int XFER_CYCLES = 1 + `LADC_DATA_W * 2 * `LADC_SCK_HALF + 2;
    localparam int HOLD_START  = 4000;
    localparam int HOLD_END    = 6000;

    logic                     clk;
    logic                     arst_n;
    logic                     cmd_valid;
    ladc_dev_t                cmd_dev;
    ladc_data_t               cmd_data;
    logic                     cmd_credit;
    logic                     rsp_credit;
    logic                     rsp_valid;
    ladc_dev_t                rsp_dev;
    ladc_data_t               rsp_data;
    logic                     sck;
    logic                     mosi;
    logic                     adc_cs_n;
    logic [`LADC_NUM_DEV-2:0] dac_cs_n;
    logic                     adc_miso;
    logic [`LADC_NUM_DEV-2:0] dac_sdo;
    logic [`LADC_NUM_DEV-1:0] cs_n_vec;
    logic [`LADC_NUM_DEV-1:0] sdo_vec;

    ladc_data_t  model [`LADC_NUM_DEV];
    ladc_dev_t   exp_dev_q [$];
    ladc_data_t  exp_data_q [$];
    ladc_dev_t   new_dev;
    ladc_data_t  new_data;
    ladc_sel_t   exp_cs_n;
    int unsigned seed;
    int          errors    = 0;
    int          cycles    = 0;
    int          pop_cycle = 0;
    int          sent      = 0;
    int          rsp_count = 0;
    int          returned  = 0;
    int          owed      = 0;
    int          cmd_cred  = `LADC_QUEUE_DEPTH;
    int          low_cnt;
    bit          in_flight = 1'b0;

    assign cs_n_vec = {dac_cs_n, adc_cs_n};
    assign adc_miso = sdo_vec[0];
    assign dac_sdo  = sdo_vec[`LADC_NUM_DEV-1:1];

    ladc_spi_top UUT (
        .clk_i        (clk),
        .arst_n_i     (arst_n),
        .cmd_valid_i  (cmd_valid),
        .cmd_dev_i    (cmd_dev),
        .cmd_data_i   (cmd_data),
        .cmd_credit_o (cmd_credit),
        .rsp_credit_i (rsp_credit),
        .rsp_valid_o  (rsp_valid),
        .rsp_dev_o    (rsp_dev),
        .rsp_data_o   (rsp_data),
        .spi_sck_o    (sck),
        .spi_mosi_o   (mosi),
        .adc_cs_n_o   (adc_cs_n),
        .dac_cs_n_o   (dac_cs_n),
        .adc_miso_i   (adc_miso),
        .dac_sdo_i    (dac_sdo)
    );

    // Device models, each returns its held word and keeps the one it receives
    for (genvar g = 0; g < `LADC_NUM_DEV; g++) begin : g_dev
        ladc_data_t held     = ladc_data_t'(16'hA500 + g);
        ladc_data_t rx_sr    = '0;
        logic [4:0] fall_cnt = '0;
        logic [4:0] rise_cnt = '0;

        always @(negedge sck or posedge cs_n_vec[g]) begin
            if (cs_n_vec[g]) begin
                fall_cnt = '0;
            end else begin
                fall_cnt = fall_cnt + 1'b1;
            end
        end

        // MSB is out from the chip select fall on
        assign sdo_vec[g] = fall_cnt[4] ? 1'b0 : held[4'd15 - fall_cnt[3:0]];

        always @(posedge sck or posedge cs_n_vec[g]) begin
            if (cs_n_vec[g]) begin
                if (rise_cnt == 5'd16) begin
                    held = rx_sr;
                end
                rise_cnt = '0;
            end else begin
                rx_sr    = {rx_sr[`LADC_DATA_W-2:0], mosi};
                rise_cnt = rise_cnt + 1'b1;
            end
        end
    end

    task automatic check_eq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            errors++;
            $display("CHECK FAILED at %0t: %s, got %0h expected %0h", $time, msg, got, exp);
        end
    endtask

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // Monitor uses values sampled at the edge, then the host drives the next cycle
    always @(posedge clk) begin
        if (arst_n) begin
            cycles++;
            if (cmd_credit) begin
                cmd_cred++;
                check_eq(32'(cmd_cred <= `LADC_QUEUE_DEPTH), 32'd1, "command credits above depth");
            end
            low_cnt = $countones(~cs_n_vec);
            if (low_cnt > 1) begin
                errors++;
                $display("More than one chip select was low at time %0t", $time);
            end else if (low_cnt == 1) begin
                if (!in_flight || exp_dev_q.size() == 0) begin
                    errors++;
                    $display("A chip select was low with no transfer running at %0t", $time);
                end else begin
                    // Only the addressed device is selected
                    for (int i = 0; i < `LADC_NUM_DEV; i++) begin
                        exp_cs_n[i] = (i != exp_dev_q[0]);
                    end
                    check_eq(32'(cs_n_vec), 32'(exp_cs_n), "chip select");
                end
            end
            if (UUT.q_pop) begin
                pop_cycle = cycles;
                in_flight = 1'b1;
            end
            if (rsp_valid) begin
                if (exp_dev_q.size() == 0) begin
                    errors++;
                    $display("A response arrived with no command pending at %0t", $time);
                end else begin
                    check_eq(32'(rsp_dev), 32'(exp_dev_q.pop_front()), "response device");
                    check_eq(32'(rsp_data), 32'(exp_data_q.pop_front()), "response data");
                end
                check_eq(32'(cycles - pop_cycle), 32'(XFER_CYCLES), "pop to response cycles");
                rsp_count++;
                owed++;
                in_flight = 1'b0;
                check_eq(32'(rsp_count <= `LADC_RSP_CREDITS + returned), 32'd1,
                         "response beyond returned credits");
                if (rsp_count == sent) begin
                    check_eq(32'(cmd_cred), 32'(`LADC_QUEUE_DEPTH), "idle command credits");
                end
            end

            cmd_valid <= 1'b0;
            if (sent < NUM_CMDS && cmd_cred > 0 && $urandom_range(1, 0) == 1) begin
                new_dev  = ladc_dev_t'($urandom_range(`LADC_NUM_DEV - 1, 0));
                new_data = ladc_data_t'($urandom);
                cmd_valid <= 1'b1;
                cmd_dev   <= new_dev;
                cmd_data  <= new_data;
                exp_dev_q.push_back(new_dev);
                exp_data_q.push_back(model[new_dev]);
                model[new_dev] = new_data;
                cmd_cred--;
                sent++;
            end

            // Credits are withheld for a long stretch in the middle of the run
            rsp_credit <= 1'b0;
            if (owed > 0 && (cycles < HOLD_START || cycles >= HOLD_END)
                    && $urandom_range(3, 0) == 0) begin
                rsp_credit <= 1'b1;
                owed--;
                returned++;
            end
        end
    end

    initial begin
        seed       = $urandom(75709);
        arst_n     = 1'b0;
        cmd_valid  = 1'b0;
        cmd_dev    = '0;
        cmd_data   = '0;
        rsp_credit = 1'b0;
        for (int i = 0; i < `LADC_NUM_DEV; i++) begin
            model[i] = ladc_data_t'(16'hA500 + i);
        end
        repeat (8) @(posedge clk);
        check_eq(32'(cs_n_vec), 32'hFF, "chip selects in reset");
        check_eq(32'({sck, mosi, rsp_valid, cmd_credit}), 32'd0, "outputs in reset");
        arst_n <= 1'b1;
        wait (rsp_count == NUM_CMDS);
        repeat (4) @(posedge clk);
        check_eq(32'(cmd_cred), 32'(`LADC_QUEUE_DEPTH), "final command credits");
        check_eq(32'(exp_dev_q.size()), 32'd0, "commands left pending");
        $display("Summary: %0d commands, %0d responses, %0d errors", sent, rsp_count, errors);
        if (errors == 0) begin
            $display("Test OK");
        end else begin
            $display("Test FAILED");
        end
        $finish;
    end

    initial begin
        repeat (TIMEOUT) @(posedge clk);
        $display("Timeout: the run did not finish within %0d cycles", TIMEOUT);
        $display("Test FAILED");
        $finish;
    end

endmodule

// ==== flist.f ====
+incdir+logic
logic/ladc_pkg.sv
logic/spi_cmd_queue.sv
logic/spi_shift_engine.sv
logic/spi_dev_router.sv
logic/ladc_spi_top.sv
verif/ladc_spi_tb.sv

// ==== run_sim.sh ====
#!/usr/bin/env bash
# Build and run the SPI front end testbench with Verilator

cd "$(dirname "$0")" || exit 1

verilator --binary --timing --assert -f flist.f --top-module ladc_spi_tb -o ladc_sim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

sim_out=$(./obj_dir/ladc_sim)
sim_status=$?
echo "$sim_out"
if [ $sim_status -ne 0 ]; then
    echo "Simulation exited with status $sim_status"
    exit 1
fi

if echo "$sim_out" | grep -qx "Test OK"; then
    exit 0
fi
exit 1
